// File: logic/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data and address width
`define CPU_XLEN 32

// general register file
`define CPU_NREGS 16
`define CPU_RADDR_W 4

// first fetch address
`define CPU_RESET_PC 32'h0000_0000

// ir[15:0]
`define CPU_IMM_W 16

`endif

// File: logic/cpu_pkg.sv
package cpu_pkg;

  // ir[31:28]
  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_OR   = 4'h3,
    OP_XOR  = 4'h4,
    OP_ADDI = 4'h5,
    OP_LDI  = 4'h6,
    OP_LD   = 4'h7,
    OP_LDB  = 4'h8,
    OP_ST   = 4'h9,
    OP_STB  = 4'ha,
    OP_BEQ  = 4'hb,
    OP_BNE  = 4'hc,
    OP_JMP  = 4'hd,
    OP_HALT = 4'he
  } opcode_e;

  typedef enum logic [2:0] {
    ST_FETCH, ST_DECODE, ST_EXEC, ST_MEM, ST_WB, ST_HALT
  } state_e;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR
  } alu_func_e;

  typedef enum logic [1:0] {PC_HOLD, PC_NEXT, PC_REL, PC_ALU} pcsel_e;
  typedef enum logic {MAR_HOLD, MAR_ALU} marsel_e;
  typedef enum logic [1:0] {MDR_HOLD, MDR_BUS, MDR_B} mdrsel_e;
  typedef enum logic [1:0] {REG_ALU, REG_MDR, REG_UVAL} regsel_e;
  typedef enum logic {ALU2_B, ALU2_SVAL} alu2sel_e;

endpackage

// File: logic/cpu_alu.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_alu (
  input  cpu_pkg::alu_func_e   func_i,
  input  logic [`CPU_XLEN-1:0] a_i,
  input  logic [`CPU_XLEN-1:0] b_i,
  output logic [`CPU_XLEN-1:0] result_o,
  output logic                 carry_o,
  output logic                 neg_o,
  output logic                 zero_o
);

  logic [`CPU_XLEN:0] sum; // extra bit is the carry

  always_comb begin
    sum = '0;
    case (func_i)
      cpu_pkg::ALU_ADD: sum = {1'b0, a_i} + {1'b0, b_i};
      cpu_pkg::ALU_SUB: sum = {1'b0, a_i} - {1'b0, b_i}; // borrow in msb
      cpu_pkg::ALU_AND: sum = {1'b0, a_i & b_i};
      cpu_pkg::ALU_OR:  sum = {1'b0, a_i | b_i};
      cpu_pkg::ALU_XOR: sum = {1'b0, a_i ^ b_i};
      default:          sum = '0;
    endcase
  end

  assign result_o = sum[`CPU_XLEN-1:0];
  assign carry_o  = sum[`CPU_XLEN];
  assign neg_o    = sum[`CPU_XLEN-1];
  assign zero_o   = (sum[`CPU_XLEN-1:0] == '0);

endmodule

// File: logic/cpu_regfile.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_regfile (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic [`CPU_RADDR_W-1:0] raddr1_i,
  input  logic [`CPU_RADDR_W-1:0] raddr2_i,
  input  logic [`CPU_RADDR_W-1:0] waddr_i,
  input  logic [`CPU_XLEN-1:0]    wdata_i,
  input  logic                    we_i,
  output logic [`CPU_XLEN-1:0]    rdata1_o,
  output logic [`CPU_XLEN-1:0]    rdata2_o
);

  logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < `CPU_NREGS; i++) regs[i] <= '0;
    end else if (we_i && waddr_i != '0) begin // r0 stays zero
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = regs[raddr1_i];
  assign rdata2_o = regs[raddr2_i];

endmodule

// File: logic/cpu_datapath.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_datapath (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  cpu_pkg::pcsel_e      pcsel_i,
  input  cpu_pkg::marsel_e     marsel_i,
  input  cpu_pkg::mdrsel_e     mdrsel_i,
  input  cpu_pkg::regsel_e     regsel_i,
  input  cpu_pkg::alu2sel_e    alu2sel_i,
  input  logic                 addrsel_i,
  input  logic                 ir_we_i,
  input  logic                 a_we_i,
  input  logic                 b_we_i,
  input  logic                 ccr_we_i,
  input  logic [`CPU_XLEN-1:0] alu_result_i,
  input  logic                 alu_carry_i,
  input  logic                 alu_neg_i,
  input  logic                 alu_zero_i,
  input  logic [`CPU_XLEN-1:0] rdata1_i,
  input  logic [`CPU_XLEN-1:0] rdata2_i,
  input  logic [`CPU_XLEN-1:0] dat_i,
  input  logic [3:0]           sel_i,
  input  logic                 we_i,
  output logic [`CPU_XLEN-1:0] ir_o,
  output logic                 zero_o,
  output logic [`CPU_XLEN-1:0] alu_a_o,
  output logic [`CPU_XLEN-1:0] alu_b_o,
  output logic [`CPU_XLEN-1:0] wdata_o,
  output logic [`CPU_XLEN-1:0] adr_o,
  output logic [`CPU_XLEN-1:0] dat_o
);

  logic [`CPU_XLEN-1:0] pc;
  logic [`CPU_XLEN-1:0] ir;
  logic [`CPU_XLEN-1:0] mar;
  logic [`CPU_XLEN-1:0] mdr;
  logic [`CPU_XLEN-1:0] a;
  logic [`CPU_XLEN-1:0] b;
  logic [2:0]           ccr; // carry, neg, zero
  logic [`CPU_XLEN-1:0] pc_next;
  logic [`CPU_XLEN-1:0] ir_sval;
  logic [`CPU_XLEN-1:0] ir_uval;
  logic [`CPU_XLEN-1:0] busin;
  logic [`CPU_XLEN-1:0] busout;

  assign ir_sval = {{(`CPU_XLEN-`CPU_IMM_W){ir[`CPU_IMM_W-1]}}, ir[`CPU_IMM_W-1:0]};
  assign ir_uval = {{(`CPU_XLEN-`CPU_IMM_W){1'b0}}, ir[`CPU_IMM_W-1:0]};

  always_comb begin
    case (pcsel_i)
      cpu_pkg::PC_NEXT: pc_next = pc + 32'd4;
      cpu_pkg::PC_REL:  pc_next = pc + {ir_sval[`CPU_XLEN-3:0], 2'b00}; // word offset
      cpu_pkg::PC_ALU:  pc_next = alu_result_i;
      default:          pc_next = pc;
    endcase
  end

  // loads land at bit 0 and stores move to their lane
  always_comb begin
    case (sel_i)
      4'b0001: begin
        busin  = {24'h0, dat_i[7:0]};
        busout = {24'h0, mdr[7:0]};
      end
      4'b0010: begin
        busin  = {24'h0, dat_i[15:8]};
        busout = {16'h0, mdr[7:0], 8'h0};
      end
      4'b0100: begin
        busin  = {24'h0, dat_i[23:16]};
        busout = {8'h0, mdr[7:0], 16'h0};
      end
      4'b1000: begin
        busin  = {24'h0, dat_i[31:24]};
        busout = {mdr[7:0], 24'h0};
      end
      default: begin
        busin  = dat_i;
        busout = mdr;
      end
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      pc  <= `CPU_RESET_PC;
      ir  <= '0;
      ccr <= '0;
    end else begin
      pc <= pc_next;
      if (ir_we_i) ir <= dat_i;
      if (ccr_we_i) ccr <= {alu_carry_i, alu_neg_i, alu_zero_i};
    end
  end

  always_ff @(posedge clk_i) begin
    if (marsel_i == cpu_pkg::MAR_ALU) mar <= alu_result_i;
    if (mdrsel_i == cpu_pkg::MDR_BUS) mdr <= busin;
    else if (mdrsel_i == cpu_pkg::MDR_B) mdr <= b;
    if (a_we_i) a <= rdata1_i;
    if (b_we_i) b <= rdata2_i;
  end

  always_comb begin
    case (regsel_i)
      cpu_pkg::REG_MDR:  wdata_o = mdr;
      cpu_pkg::REG_UVAL: wdata_o = ir_uval;
      default:           wdata_o = alu_result_i;
    endcase
  end

  assign alu_a_o = a;
  assign alu_b_o = (alu2sel_i == cpu_pkg::ALU2_SVAL) ? ir_sval : b;
  assign ir_o    = ir;
  assign zero_o  = ccr[0];
  assign adr_o   = addrsel_i ? mar : pc;
  assign dat_o   = we_i ? busout : '0;

endmodule

// File: logic/cpu_control.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_control (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic [`CPU_XLEN-1:0]    ir_i,
  input  logic                    zero_i,
  input  logic                    ack_i,
  input  logic [1:0]              align_i,
  output logic                    ir_we_o,
  output logic                    a_we_o,
  output logic                    b_we_o,
  output logic                    ccr_we_o,
  output logic                    reg_we_o,
  output cpu_pkg::pcsel_e         pcsel_o,
  output cpu_pkg::marsel_e        marsel_o,
  output cpu_pkg::mdrsel_e        mdrsel_o,
  output cpu_pkg::regsel_e        regsel_o,
  output cpu_pkg::alu2sel_e       alu2sel_o,
  output cpu_pkg::alu_func_e      alu_func_o,
  output logic [`CPU_RADDR_W-1:0] raddr1_o,
  output logic [`CPU_RADDR_W-1:0] raddr2_o,
  output logic [`CPU_RADDR_W-1:0] waddr_o,
  output logic                    addrsel_o,
  output logic                    cyc_o,
  output logic                    we_o,
  output logic [3:0]              sel_o,
  output logic                    halt_o
);

  cpu_pkg::state_e  state;
  cpu_pkg::state_e  state_next;
  cpu_pkg::opcode_e op;
  logic             bus_done;
  logic             byte_op;
  logic             store_op;

  assign op       = cpu_pkg::opcode_e'(ir_i[31:28]);
  assign bus_done = cyc_o & ack_i;
  assign byte_op  = (op == cpu_pkg::OP_LDB) || (op == cpu_pkg::OP_STB);
  assign store_op = (op == cpu_pkg::OP_ST) || (op == cpu_pkg::OP_STB);

  // rb feeds a, b gets rc or the store source; jmp adds r0
  assign raddr1_o = ir_i[23:20];
  assign raddr2_o = store_op ? ir_i[27:24] :
                    (op == cpu_pkg::OP_JMP) ? '0 : ir_i[19:16];
  assign waddr_o  = ir_i[27:24];

  assign addrsel_o = (state == cpu_pkg::ST_MEM); // mar on data cycles
  assign sel_o     = (addrsel_o && byte_op) ? (4'b0001 << align_i) : 4'b1111;
  assign halt_o    = (state == cpu_pkg::ST_HALT);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state <= cpu_pkg::ST_FETCH;
      cyc_o <= 1'b0;
      we_o  <= 1'b0;
    end else begin
      state <= state_next;
      case (state)
        cpu_pkg::ST_FETCH: cyc_o <= ~bus_done;
        cpu_pkg::ST_EXEC: begin
          cyc_o <= (state_next == cpu_pkg::ST_MEM);
          we_o  <= (state_next == cpu_pkg::ST_MEM) && store_op;
        end
        cpu_pkg::ST_MEM: if (bus_done) begin
          cyc_o <= 1'b0;
          we_o  <= 1'b0;
        end
        default: cyc_o <= 1'b0;
      endcase
    end
  end

  always_comb begin
    state_next = state;
    ir_we_o    = 1'b0;
    a_we_o     = 1'b0;
    b_we_o     = 1'b0;
    ccr_we_o   = 1'b0;
    reg_we_o   = 1'b0;
    pcsel_o    = cpu_pkg::PC_HOLD;
    marsel_o   = cpu_pkg::MAR_HOLD;
    mdrsel_o   = cpu_pkg::MDR_HOLD;
    regsel_o   = cpu_pkg::REG_ALU;
    alu2sel_o  = cpu_pkg::ALU2_B;
    alu_func_o = cpu_pkg::ALU_ADD;
    case (state)
      cpu_pkg::ST_FETCH: if (bus_done) begin
        ir_we_o    = 1'b1;
        pcsel_o    = cpu_pkg::PC_NEXT; // pc now points past this insn
        state_next = cpu_pkg::ST_DECODE;
      end
      cpu_pkg::ST_DECODE: begin
        a_we_o     = 1'b1;
        b_we_o     = 1'b1;
        state_next = cpu_pkg::ST_EXEC;
      end
      cpu_pkg::ST_EXEC: begin
        state_next = cpu_pkg::ST_FETCH;
        case (op)
          cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
          cpu_pkg::OP_OR, cpu_pkg::OP_XOR: begin
            case (op)
              cpu_pkg::OP_SUB: alu_func_o = cpu_pkg::ALU_SUB;
              cpu_pkg::OP_AND: alu_func_o = cpu_pkg::ALU_AND;
              cpu_pkg::OP_OR:  alu_func_o = cpu_pkg::ALU_OR;
              cpu_pkg::OP_XOR: alu_func_o = cpu_pkg::ALU_XOR;
              default:         alu_func_o = cpu_pkg::ALU_ADD;
            endcase
            reg_we_o = 1'b1;
            ccr_we_o = 1'b1;
          end
          cpu_pkg::OP_ADDI: begin
            alu2sel_o = cpu_pkg::ALU2_SVAL;
            reg_we_o  = 1'b1;
            ccr_we_o  = 1'b1;
          end
          cpu_pkg::OP_LDI: begin
            regsel_o = cpu_pkg::REG_UVAL;
            reg_we_o = 1'b1;
          end
          cpu_pkg::OP_LD, cpu_pkg::OP_LDB, cpu_pkg::OP_ST, cpu_pkg::OP_STB: begin
            alu2sel_o  = cpu_pkg::ALU2_SVAL; // rb + offset
            marsel_o   = cpu_pkg::MAR_ALU;
            mdrsel_o   = store_op ? cpu_pkg::MDR_B : cpu_pkg::MDR_HOLD;
            state_next = cpu_pkg::ST_MEM;
          end
          cpu_pkg::OP_BEQ: if (zero_i) pcsel_o = cpu_pkg::PC_REL;
          cpu_pkg::OP_BNE: if (!zero_i) pcsel_o = cpu_pkg::PC_REL;
          cpu_pkg::OP_JMP: pcsel_o = cpu_pkg::PC_ALU;
          cpu_pkg::OP_HALT: state_next = cpu_pkg::ST_HALT;
          default: state_next = cpu_pkg::ST_FETCH; // unused opcode acts as nop
        endcase
      end
      cpu_pkg::ST_MEM: if (bus_done) begin
        if (!store_op) begin
          mdrsel_o   = cpu_pkg::MDR_BUS;
          state_next = cpu_pkg::ST_WB;
        end else begin
          state_next = cpu_pkg::ST_FETCH;
        end
      end
      cpu_pkg::ST_WB: begin
        regsel_o   = cpu_pkg::REG_MDR;
        reg_we_o   = 1'b1;
        state_next = cpu_pkg::ST_FETCH;
      end
      default: state_next = cpu_pkg::ST_HALT;
    endcase
  end

endmodule

// File: logic/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_top (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 ack_i,
  input  logic [`CPU_XLEN-1:0] dat_i,
  output logic                 cyc_o,
  output logic                 we_o,
  output logic [`CPU_XLEN-1:0] adr_o,
  output logic [`CPU_XLEN-1:0] dat_o,
  output logic [3:0]           sel_o,
  output logic                 halt_o
);

  cpu_pkg::pcsel_e         pcsel;
  cpu_pkg::marsel_e        marsel;
  cpu_pkg::mdrsel_e        mdrsel;
  cpu_pkg::regsel_e        regsel;
  cpu_pkg::alu2sel_e       alu2sel;
  cpu_pkg::alu_func_e      alu_func;
  logic                    ir_we;
  logic                    a_we;
  logic                    b_we;
  logic                    ccr_we;
  logic                    reg_we;
  logic                    addrsel;
  logic                    ccr_zero;
  logic [`CPU_RADDR_W-1:0] raddr1;
  logic [`CPU_RADDR_W-1:0] raddr2;
  logic [`CPU_RADDR_W-1:0] waddr;
  logic [`CPU_XLEN-1:0]    ir;
  logic [`CPU_XLEN-1:0]    alu_a;
  logic [`CPU_XLEN-1:0]    alu_b;
  logic [`CPU_XLEN-1:0]    alu_result;
  logic                    alu_carry;
  logic                    alu_neg;
  logic                    alu_zero;
  logic [`CPU_XLEN-1:0]    rdata1;
  logic [`CPU_XLEN-1:0]    rdata2;
  logic [`CPU_XLEN-1:0]    wdata;

  cpu_control ctrl0 (
    .clk_i(clk_i), .rst_i(rst_i), .ir_i(ir), .zero_i(ccr_zero), .ack_i(ack_i),
    .align_i(adr_o[1:0]), .ir_we_o(ir_we), .a_we_o(a_we), .b_we_o(b_we),
    .ccr_we_o(ccr_we), .reg_we_o(reg_we), .pcsel_o(pcsel), .marsel_o(marsel),
    .mdrsel_o(mdrsel), .regsel_o(regsel), .alu2sel_o(alu2sel), .alu_func_o(alu_func),
    .raddr1_o(raddr1), .raddr2_o(raddr2), .waddr_o(waddr), .addrsel_o(addrsel),
    .cyc_o(cyc_o), .we_o(we_o), .sel_o(sel_o), .halt_o(halt_o)
  );

  cpu_datapath dp0 (
    .clk_i(clk_i), .rst_i(rst_i), .pcsel_i(pcsel), .marsel_i(marsel),
    .mdrsel_i(mdrsel), .regsel_i(regsel), .alu2sel_i(alu2sel), .addrsel_i(addrsel),
    .ir_we_i(ir_we), .a_we_i(a_we), .b_we_i(b_we), .ccr_we_i(ccr_we),
    .alu_result_i(alu_result), .alu_carry_i(alu_carry), .alu_neg_i(alu_neg),
    .alu_zero_i(alu_zero), .rdata1_i(rdata1), .rdata2_i(rdata2), .dat_i(dat_i),
    .sel_i(sel_o), .we_i(we_o), .ir_o(ir), .zero_o(ccr_zero), .alu_a_o(alu_a),
    .alu_b_o(alu_b), .wdata_o(wdata), .adr_o(adr_o), .dat_o(dat_o)
  );

  cpu_alu alu0 (
    .func_i(alu_func), .a_i(alu_a), .b_i(alu_b), .result_o(alu_result),
    .carry_o(alu_carry), .neg_o(alu_neg), .zero_o(alu_zero)
  );

  cpu_regfile regs0 (
    .clk_i(clk_i), .rst_i(rst_i), .raddr1_i(raddr1), .raddr2_i(raddr2),
    .waddr_i(waddr), .wdata_i(wdata), .we_i(reg_we),
    .rdata1_o(rdata1), .rdata2_o(rdata2)
  );

endmodule

// File: verif/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_tb;

  localparam int IMAGE_WORDS = 64;
  localparam int TDATA_WORDS = IMAGE_WORDS + 1 + 3 * 17; // image, count, 17 stores
  localparam int CYCLE_LIMIT = 40 * IMAGE_WORDS;

  logic                 clk_i;
  logic                 rst_i;
  logic                 ack_i;
  logic [`CPU_XLEN-1:0] dat_i;
  logic                 cyc_o;
  logic                 we_o;
  logic [`CPU_XLEN-1:0] adr_o;
  logic [`CPU_XLEN-1:0] dat_o;
  logic [3:0]           sel_o;
  logic                 halt_o;

  logic [31:0] tdata [0:TDATA_WORDS-1];
  logic [31:0] mem [0:IMAGE_WORDS-1];
  int          n_expected;
  int          n_stores;
  int          cycles;
  int          wait_left;
  int          seed_val;
  logic        in_cycle;
  logic [31:0] held_adr;
  logic [31:0] held_dat;
  logic [3:0]  held_sel;
  logic        held_we;

  cpu_top dut0 (
    .clk_i(clk_i), .rst_i(rst_i), .ack_i(ack_i), .dat_i(dat_i),
    .cyc_o(cyc_o), .we_o(we_o), .adr_o(adr_o), .dat_o(dat_o),
    .sel_o(sel_o), .halt_o(halt_o)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1, "simulation stopped on error");
  endtask

  function automatic string mismatch_text(input string name, input logic [31:0] got,
                                          input logic [31:0] exp);
    return $sformatf("FAILED %s got %08h expected %08h", name, got, exp);
  endfunction

  // compare against the next expected store record
  task automatic check_store();
    int base;
    base = IMAGE_WORDS + 1 + 3 * n_stores;
    assert (n_stores < n_expected) else fail_run("core issued more stores than expected");
    assert (adr_o == tdata[base]) else fail_run(mismatch_text("adr_o", adr_o, tdata[base]));
    assert (dat_o == tdata[base+1])
      else fail_run(mismatch_text("dat_o", dat_o, tdata[base+1]));
    assert (sel_o == tdata[base+2][3:0])
      else fail_run(mismatch_text("sel_o", {28'h0, sel_o}, tdata[base+2]));
    n_stores++;
  endtask

  task automatic write_mem();
    logic [31:0] word;
    word = mem[adr_o[7:2]];
    for (int i = 0; i < 4; i++) begin
      if (sel_o[i]) word[8*i +: 8] = dat_o[8*i +: 8];
    end
    mem[adr_o[7:2]] = word;
  endtask

  task automatic serve_transfer();
    assert (adr_o[31:8] == '0) else fail_run("core addressed memory outside the test image");
    if (we_o) begin
      check_store();
      write_mem();
    end else begin
      assert (dat_o == '0) else fail_run(mismatch_text("dat_o", dat_o, 32'h0));
      dat_i = mem[adr_o[7:2]];
    end
  endtask

  // bus slave that waits 0 to 3 random cycles before ack
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (ack_i) begin
        ack_i    = 1'b0; // taken on the last rising edge
        dat_i    = '0;
        in_cycle = 1'b0;
      end else if (cyc_o) begin
        if (!in_cycle) begin
          in_cycle  = 1'b1;
          wait_left = $urandom % 4;
          held_adr  = adr_o;
          held_dat  = dat_o;
          held_sel  = sel_o;
          held_we   = we_o;
        end else begin
          assert (adr_o == held_adr) else fail_run(mismatch_text("adr_o", adr_o, held_adr));
          assert (dat_o == held_dat) else fail_run(mismatch_text("dat_o", dat_o, held_dat));
          assert (sel_o == held_sel)
            else fail_run(mismatch_text("sel_o", {28'h0, sel_o}, {28'h0, held_sel}));
          assert (we_o == held_we)
            else fail_run(mismatch_text("we_o", {31'h0, we_o}, {31'h0, held_we}));
        end
        if (wait_left == 0) begin
          serve_transfer();
          ack_i = 1'b1;
        end else begin
          wait_left--;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    if (!rst_i) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT)
        fail_run($sformatf("core never halted within %0d cycles", CYCLE_LIMIT));
    end
  end

  initial begin
    seed_val  = $urandom(93627);
    rst_i     = 1'b1;
    ack_i     = 1'b0;
    dat_i     = '0;
    in_cycle  = 1'b0;
    wait_left = 0;
    n_stores  = 0;
    cycles    = 0;
    $readmemh("verif/cpu_testdata.hex", tdata);
    for (int i = 0; i < IMAGE_WORDS; i++) mem[i] = tdata[i];
    n_expected = tdata[IMAGE_WORDS];

    repeat (4) @(negedge clk_i);
    assert (!cyc_o && !we_o && !halt_o) else fail_run("bus or halt active during reset");
    assert (sel_o == 4'b1111) else fail_run(mismatch_text("sel_o", {28'h0, sel_o}, 32'hf));
    rst_i = 1'b0;

    wait (halt_o === 1'b1);
    @(negedge clk_i);
    assert (n_stores == n_expected)
      else fail_run(mismatch_text("store count", n_stores, n_expected));
    // halted core stays quiet on the bus
    repeat (8) begin
      @(negedge clk_i);
      assert (!cyc_o) else fail_run("bus cycle started after halt");
      assert (halt_o) else fail_run("halt_o dropped after halt");
    end
    $display("all tests passed");
    $finish;
  end

endmodule

// File: sim.f
+incdir+logic
logic/cpu_pkg.sv
logic/cpu_alu.sv
logic/cpu_regfile.sv
logic/cpu_datapath.sv
logic/cpu_control.sv
logic/cpu_top.sv
verif/cpu_tb.sv

// File: verif/cpu_testdata.hex
// words 0-63: memory image, eight words per line (program, then data from 0xc0)
// word 64: expected store count, then one store per line as address data sel
610000C0 62001234 6300F00F 04230000 94100020 15230000 26230000 37230000
48230000 5920FFF0 95100024 96100028 9710002C 98100030 99100034 7A100004
9A100038 8B100005 9B10003C 8C100007 9C100020 A2100008 A3100009 A410000A
A510000B 7D100008 9D100024 1E220000 B0000001 93100028 6F0000AA C0000001
9F100028 5EE00001 B0000001 9E10002C C0000002 93100030 E0000000 6F0000B4
D0F00000 93100030 E0000000 93100030 E0000000 9F100030 E0000000 00000000
12345678 A1B2C3D4 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000011
000000E0 00010243 0000000F // add
000000E4 FFFF2225 0000000F // sub
000000E8 00001004 0000000F
000000EC 0000F23F 0000000F
000000F0 0000E23B 0000000F
000000F4 00001224 0000000F // addi with negative immediate
000000F8 A1B2C3D4 0000000F // word load copied out
000000FC 000000C3 0000000F
000000E0 000000A1 0000000F
000000C8 00000034 00000001 // byte stores, one per lane
000000C9 00000F00 00000002
000000CA 00430000 00000004
000000CB 25000000 00000008
000000E4 25430F34 0000000F // merged word
000000E8 000000AA 0000000F // bne not taken
000000EC 00000001 0000000F // beq not taken
000000F0 000000B4 0000000F // jmp target
